// ==== verilog/decode_config.svh ====
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Word and field widths
`define INST_W          32
`define OPCODE_W        6
`define FUNCT_W         6
`define REG_ADDR_W      5
`define SHAMT_W         5
`define IMM_W           16

// COP0 sub-op sits in the rs field
`define RS_LSB          21

`define LINK_REG        5'd31           // r31 for branch-and-link
`define ERET_WORD       32'h4200_0018   // Whole COP0 ERET word

`endif

// ==== verilog/decode_pkg.sv ====
`include "decode_config.svh"

package decode_pkg;

        typedef enum logic [5:0] {
                ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
                ALU_SLT, ALU_SLTU,
                ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
                ALU_LUI,
                ALU_SLL, ALU_SRL, ALU_SRA,
                ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU,
                ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO,
                ALU_BREK, ALU_SYSC, ALU_ERET, ALU_MFC0, ALU_MTC0,
                ALU_OUTA                                // Pass operand A as link address
        } alu_op_e;

        typedef enum logic [1:0] {
                SRC_REG,
                SRC_IMM,
                SRC_SFT,
                SRC_PCA
        } alu_src_e;

        typedef enum logic [1:0] {
                MEM_NOOP,
                MEM_LOAD,
                MEM_STOR
        } mem_type_e;

        // Codes 3 and 4 left free for unaligned word accesses
        typedef enum logic [2:0] {
                SZ_BYTE,
                SZ_HALF,
                SZ_FULL
        } mem_size_e;

        typedef struct packed {
                logic [`REG_ADDR_W-1:0] rd;
                logic [`SHAMT_W-1:0]    shamt;
                logic [`FUNCT_W-1:0]    funct;
        } r_fields_t;

        typedef union packed {
                r_fields_t              r;      // R-type view
                logic [`IMM_W-1:0]      imm;    // I-type view
        } low_fields_u;

        typedef struct packed {
                logic [`OPCODE_W-1:0]   opcode;
                logic [`REG_ADDR_W-1:0] rs;
                logic [`REG_ADDR_W-1:0] rt;
                low_fields_u            low;
        } inst_fields_t;

        typedef struct packed {
                alu_op_e                alu_op;
                alu_src_e               alu_src;
                logic                   imm_signed;     // Sign-extend the 16-bit field
                mem_type_e              mem_type;
                mem_size_e              mem_size;
                logic [`REG_ADDR_W-1:0] wb_reg_dest;
                logic                   wb_reg_en;
                logic                   load_signed;    // Extend loaded data by sign
                logic                   priv_inst;
                logic                   undefined_inst;
        } decode_ctrl_t;

endpackage

// ==== verilog/branch_detect.sv ====
`timescale 1ns/1ns

module branch_detect (
        input  decode_pkg::inst_fields_t        fields,
        output logic                            is_branch,
        output logic                            is_link
);

        always_comb begin
                is_branch = 1'b0;
                is_link   = 1'b0;
                case (fields.opcode)
                6'b000000: begin                        // JR and JALR under SPECIAL
                        is_branch = (fields.low.r.funct == 6'b001000) ||
                                    (fields.low.r.funct == 6'b001001);
                        is_link   = (fields.low.r.funct == 6'b001001);
                end
                6'b000001: begin                        // REGIMM
                        // BLTZ, BGEZ and their AL forms differ only in rt[4] and rt[0]
                        is_branch = (fields.rt[3:1] == 3'b000);
                        is_link   = (fields.rt[3:1] == 3'b000) && fields.rt[4];
                end
                6'b000010: begin                        // J
                        is_branch = 1'b1;
                end
                6'b000011: begin                        // JAL
                        is_branch = 1'b1;
                        is_link   = 1'b1;
                end
                6'b000100, 6'b000101, 6'b000110, 6'b000111: begin
                        is_branch = 1'b1;               // BEQ, BNE, BLEZ, BGTZ
                end
                default: begin
                        is_branch = 1'b0;
                end
                endcase
        end

endmodule

// ==== verilog/ctrl_decode.sv ====
`timescale 1ns/1ns
`include "decode_config.svh"

module ctrl_decode (
        input  decode_pkg::inst_fields_t        fields,
        input  logic [`INST_W-1:0]              instruction,
        input  logic                            is_branch,
        input  logic                            is_link,
        output decode_pkg::decode_ctrl_t        ctrl
);

        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] cop0_sub;

        assign rd       = fields.low.r.rd;
        assign rt       = fields.rt;
        assign cop0_sub = instruction[`RS_LSB +: `REG_ADDR_W];

        // Register-operand row without memory access
        function automatic decode_pkg::decode_ctrl_t reg_op(
                input decode_pkg::alu_op_e      op,
                input decode_pkg::alu_src_e     src,
                input logic [`REG_ADDR_W-1:0]   dest,
                input logic                     en
        );
                decode_pkg::decode_ctrl_t c;
                c             = '0;
                c.alu_op      = op;
                c.alu_src     = src;
                c.mem_type    = decode_pkg::MEM_NOOP;
                c.mem_size    = decode_pkg::SZ_FULL;
                c.wb_reg_dest = en ? dest : '0;
                c.wb_reg_en   = en;
                return c;
        endfunction

        function automatic decode_pkg::decode_ctrl_t imm_op(
                input decode_pkg::alu_op_e      op,
                input logic                     imm_s,
                input logic [`REG_ADDR_W-1:0]   dest
        );
                decode_pkg::decode_ctrl_t c;
                c            = reg_op(op, decode_pkg::SRC_IMM, dest, 1'b1);
                c.imm_signed = imm_s;
                return c;
        endfunction

        // Address is base plus signed offset
        function automatic decode_pkg::decode_ctrl_t mem_op(
                input decode_pkg::mem_type_e    mt,
                input decode_pkg::mem_size_e    ms,
                input logic                     ld_s,
                input logic [`REG_ADDR_W-1:0]   dest
        );
                decode_pkg::decode_ctrl_t c;
                c             = imm_op(decode_pkg::ALU_ADDU, 1'b1, dest);
                c.mem_type    = mt;
                c.mem_size    = ms;
                c.wb_reg_en   = (mt == decode_pkg::MEM_LOAD);
                c.wb_reg_dest = (mt == decode_pkg::MEM_LOAD) ? dest : '0;
                c.load_signed = ld_s;
                return c;
        endfunction

        always_comb begin
                ctrl = reg_op(decode_pkg::ALU_ADDU, decode_pkg::SRC_REG, rt, 1'b0);
                casez ({fields.opcode, fields.low.r.funct})
                {6'b000000, 6'b100000}:
                        ctrl = reg_op(decode_pkg::ALU_ADD, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b100001}:
                        ctrl = reg_op(decode_pkg::ALU_ADDU, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b100010}:
                        ctrl = reg_op(decode_pkg::ALU_SUB, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b100011}:
                        ctrl = reg_op(decode_pkg::ALU_SUBU, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b101010}:
                        ctrl = reg_op(decode_pkg::ALU_SLT, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b101011}:
                        ctrl = reg_op(decode_pkg::ALU_SLTU, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b100100}:
                        ctrl = reg_op(decode_pkg::ALU_AND, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b100101}:
                        ctrl = reg_op(decode_pkg::ALU_OR, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b100110}:
                        ctrl = reg_op(decode_pkg::ALU_XOR, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b100111}:
                        ctrl = reg_op(decode_pkg::ALU_NOR, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b000000}:
                        ctrl = reg_op(decode_pkg::ALU_SLL, decode_pkg::SRC_SFT, rd, 1'b1);
                {6'b000000, 6'b000010}:
                        ctrl = reg_op(decode_pkg::ALU_SRL, decode_pkg::SRC_SFT, rd, 1'b1);
                {6'b000000, 6'b000011}:
                        ctrl = reg_op(decode_pkg::ALU_SRA, decode_pkg::SRC_SFT, rd, 1'b1);
                {6'b000000, 6'b000100}:
                        ctrl = reg_op(decode_pkg::ALU_SLL, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b000110}:
                        ctrl = reg_op(decode_pkg::ALU_SRL, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b000111}:
                        ctrl = reg_op(decode_pkg::ALU_SRA, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b010000}:
                        ctrl = reg_op(decode_pkg::ALU_MFHI, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b010010}:
                        ctrl = reg_op(decode_pkg::ALU_MFLO, decode_pkg::SRC_REG, rd, 1'b1);
                {6'b000000, 6'b010001}:
                        ctrl = reg_op(decode_pkg::ALU_MTHI, decode_pkg::SRC_REG, rd, 1'b0);
                {6'b000000, 6'b010011}:
                        ctrl = reg_op(decode_pkg::ALU_MTLO, decode_pkg::SRC_REG, rd, 1'b0);
                {6'b000000, 6'b011000}:
                        ctrl = reg_op(decode_pkg::ALU_MULT, decode_pkg::SRC_REG, rd, 1'b0);
                {6'b000000, 6'b011001}:
                        ctrl = reg_op(decode_pkg::ALU_MULTU, decode_pkg::SRC_REG, rd, 1'b0);
                {6'b000000, 6'b011010}:
                        ctrl = reg_op(decode_pkg::ALU_DIV, decode_pkg::SRC_REG, rd, 1'b0);
                {6'b000000, 6'b011011}:
                        ctrl = reg_op(decode_pkg::ALU_DIVU, decode_pkg::SRC_REG, rd, 1'b0);
                {6'b000000, 6'b001101}: begin           // BREAK
                        ctrl = reg_op(decode_pkg::ALU_BREK, decode_pkg::SRC_REG, rt, 1'b0);
                        ctrl.priv_inst = 1'b1;
                end
                {6'b000000, 6'b001100}: begin           // SYSCALL
                        ctrl = reg_op(decode_pkg::ALU_SYSC, decode_pkg::SRC_REG, rt, 1'b0);
                        ctrl.priv_inst = 1'b1;
                end
                {6'b001000, 6'b??????}: ctrl = imm_op(decode_pkg::ALU_ADD, 1'b1, rt);
                {6'b001001, 6'b??????}: ctrl = imm_op(decode_pkg::ALU_ADDU, 1'b1, rt);
                {6'b001010, 6'b??????}: ctrl = imm_op(decode_pkg::ALU_SLT, 1'b1, rt);
                {6'b001011, 6'b??????}: ctrl = imm_op(decode_pkg::ALU_SLTU, 1'b1, rt);
                {6'b001100, 6'b??????}: ctrl = imm_op(decode_pkg::ALU_AND, 1'b0, rt);
                {6'b001101, 6'b??????}: ctrl = imm_op(decode_pkg::ALU_OR, 1'b0, rt);
                {6'b001110, 6'b??????}: ctrl = imm_op(decode_pkg::ALU_XOR, 1'b0, rt);
                {6'b001111, 6'b??????}: ctrl = imm_op(decode_pkg::ALU_LUI, 1'b0, rt);
                {6'b100000, 6'b??????}:
                        ctrl = mem_op(decode_pkg::MEM_LOAD, decode_pkg::SZ_BYTE, 1'b1, rt);
                {6'b100001, 6'b??????}:
                        ctrl = mem_op(decode_pkg::MEM_LOAD, decode_pkg::SZ_HALF, 1'b1, rt);
                {6'b100011, 6'b??????}:
                        ctrl = mem_op(decode_pkg::MEM_LOAD, decode_pkg::SZ_FULL, 1'b0, rt);
                {6'b100100, 6'b??????}:
                        ctrl = mem_op(decode_pkg::MEM_LOAD, decode_pkg::SZ_BYTE, 1'b0, rt);
                {6'b100101, 6'b??????}:
                        ctrl = mem_op(decode_pkg::MEM_LOAD, decode_pkg::SZ_HALF, 1'b0, rt);
                {6'b101000, 6'b??????}:
                        ctrl = mem_op(decode_pkg::MEM_STOR, decode_pkg::SZ_BYTE, 1'b0, rt);
                {6'b101001, 6'b??????}:
                        ctrl = mem_op(decode_pkg::MEM_STOR, decode_pkg::SZ_HALF, 1'b0, rt);
                {6'b101011, 6'b??????}:
                        ctrl = mem_op(decode_pkg::MEM_STOR, decode_pkg::SZ_FULL, 1'b0, rt);
                {6'b010000, 6'b??????}: begin           // COP0
                        if (instruction == `ERET_WORD) begin
                                ctrl = reg_op(decode_pkg::ALU_ERET, decode_pkg::SRC_REG,
                                              rt, 1'b0);
                                ctrl.priv_inst = 1'b1;
                        end else if (cop0_sub == 5'b00000) begin
                                ctrl = reg_op(decode_pkg::ALU_MFC0, decode_pkg::SRC_REG,
                                              rt, 1'b1);
                                ctrl.priv_inst = 1'b1;
                        end else if (cop0_sub == 5'b00100) begin
                                ctrl = reg_op(decode_pkg::ALU_MTC0, decode_pkg::SRC_REG,
                                              rt, 1'b0);
                                ctrl.priv_inst = 1'b1;
                        end else begin
                                ctrl.undefined_inst = 1'b1;     // WAIT and other COP0 ops
                        end
                end
                default: begin
                        if (is_branch && is_link) begin
                                ctrl = reg_op(decode_pkg::ALU_OUTA, decode_pkg::SRC_PCA,
                                              `LINK_REG, 1'b1);
                        end else begin
                                ctrl.undefined_inst = ~is_branch;
                        end
                end
                endcase
        end

        // Holds across every table row, the link path and the fallback
        always_comb begin
                assert (!(ctrl.wb_reg_en && ctrl.mem_type == decode_pkg::MEM_STOR))
                        else $error("ctrl_decode: store decoded with register write");
        end

endmodule

// ==== verilog/imm_extend.sv ====
`timescale 1ns/1ns
`include "decode_config.svh"

module imm_extend (
        input  decode_pkg::inst_fields_t        fields,
        input  decode_pkg::alu_src_e            alu_src,
        input  logic                            imm_signed,
        output logic [`INST_W-1:0]              imm
);

        always_comb begin
                case (alu_src)
                decode_pkg::SRC_IMM: begin
                        if (imm_signed)
                                imm = {{(`INST_W-`IMM_W){fields.low.imm[`IMM_W-1]}},
                                       fields.low.imm};
                        else
                                imm = {{(`INST_W-`IMM_W){1'b0}}, fields.low.imm};
                end
                decode_pkg::SRC_SFT: begin
                        imm = {{(`INST_W-`SHAMT_W){1'b0}}, fields.low.r.shamt};
                end
                default: begin                          // REG and PCA take no immediate
                        imm = '0;
                end
                endcase
        end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns
`include "decode_config.svh"

module decode_stage (
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            inst_valid,
        input  logic                            hold,
        input  logic [`INST_W-1:0]              instruction,
        output logic                            out_valid,
        output decode_pkg::decode_ctrl_t        ctrl,
        output logic [`INST_W-1:0]              imm
);

        decode_pkg::inst_fields_t       fields;
        decode_pkg::decode_ctrl_t       ctrl_next;
        logic [`INST_W-1:0]             imm_next;
        logic                           is_branch;
        logic                           is_link;

        assign fields = decode_pkg::inst_fields_t'(instruction);

        branch_detect u_branch_detect (
                .fields         (fields),
                .is_branch      (is_branch),
                .is_link        (is_link)
        );

        ctrl_decode u_ctrl_decode (
                .fields         (fields),
                .instruction    (instruction),
                .is_branch      (is_branch),
                .is_link        (is_link),
                .ctrl           (ctrl_next)
        );

        imm_extend u_imm_extend (
                .fields         (fields),
                .alu_src        (ctrl_next.alu_src),
                .imm_signed     (ctrl_next.imm_signed),
                .imm            (imm_next)
        );

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                        ctrl      <= '0;
                end else if (!hold) begin               // Hold freezes the whole stage
                        out_valid <= inst_valid;
                        ctrl      <= ctrl_next;
                end
        end

        always_ff @(posedge clk) begin
                if (!hold)
                        imm <= imm_next;
        end

        assert property (@(posedge clk) !rst_n |=> !out_valid)
                else $error("decode_stage: out_valid high after reset");

endmodule

// ==== verif/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected control bundle for one instruction word
function automatic decode_pkg::decode_ctrl_t model_ctrl(input logic [`INST_W-1:0] w);
        decode_pkg::decode_ctrl_t base;
        decode_pkg::decode_ctrl_t c;
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] rt;
        logic       wr;
        logic       hit;
        logic       link;
        logic       branch;
        op                = w[31:26];
        fn                = w[5:0];
        rt                = w[20:16];
        base              = '0;
        base.alu_op       = decode_pkg::ALU_ADDU;       // Harmless default row
        base.mem_size     = decode_pkg::SZ_FULL;
        c                 = base;
        c.wb_reg_dest     = rt;
        wr                = 1'b1;
        hit               = 1'b1;
        case (op)
        6'h00: begin
                c.wb_reg_dest = w[15:11];               // R-type writes rd
                case (fn)
                6'h20: c.alu_op = decode_pkg::ALU_ADD;
                6'h21: c.alu_op = decode_pkg::ALU_ADDU;
                6'h22: c.alu_op = decode_pkg::ALU_SUB;
                6'h23: c.alu_op = decode_pkg::ALU_SUBU;
                6'h2a: c.alu_op = decode_pkg::ALU_SLT;
                6'h2b: c.alu_op = decode_pkg::ALU_SLTU;
                6'h24: c.alu_op = decode_pkg::ALU_AND;
                6'h25: c.alu_op = decode_pkg::ALU_OR;
                6'h26: c.alu_op = decode_pkg::ALU_XOR;
                6'h27: c.alu_op = decode_pkg::ALU_NOR;
                6'h00, 6'h04: c.alu_op = decode_pkg::ALU_SLL;
                6'h02, 6'h06: c.alu_op = decode_pkg::ALU_SRL;
                6'h03, 6'h07: c.alu_op = decode_pkg::ALU_SRA;
                6'h10: c.alu_op = decode_pkg::ALU_MFHI;
                6'h12: c.alu_op = decode_pkg::ALU_MFLO;
                6'h11: c.alu_op = decode_pkg::ALU_MTHI;
                6'h13: c.alu_op = decode_pkg::ALU_MTLO;
                6'h18: c.alu_op = decode_pkg::ALU_MULT;
                6'h19: c.alu_op = decode_pkg::ALU_MULTU;
                6'h1a: c.alu_op = decode_pkg::ALU_DIV;
                6'h1b: c.alu_op = decode_pkg::ALU_DIVU;
                6'h0d: c.alu_op = decode_pkg::ALU_BREK;
                6'h0c: c.alu_op = decode_pkg::ALU_SYSC;
                default: hit = 1'b0;
                endcase
                if (fn inside {6'h00, 6'h02, 6'h03})
                        c.alu_src = decode_pkg::SRC_SFT;        // Constant shift amount
                wr = !(fn inside {6'h11, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h0c, 6'h0d});
                c.priv_inst = fn inside {6'h0c, 6'h0d};
        end
        6'h08: c.alu_op = decode_pkg::ALU_ADD;
        6'h09: c.alu_op = decode_pkg::ALU_ADDU;
        6'h0a: c.alu_op = decode_pkg::ALU_SLT;
        6'h0b: c.alu_op = decode_pkg::ALU_SLTU;
        6'h0c: c.alu_op = decode_pkg::ALU_AND;
        6'h0d: c.alu_op = decode_pkg::ALU_OR;
        6'h0e: c.alu_op = decode_pkg::ALU_XOR;
        6'h0f: c.alu_op = decode_pkg::ALU_LUI;
        6'h20, 6'h21, 6'h23, 6'h24, 6'h25: c.mem_type = decode_pkg::MEM_LOAD;
        6'h28, 6'h29, 6'h2b: c.mem_type = decode_pkg::MEM_STOR;
        6'h10: begin
                c.priv_inst = 1'b1;
                if (w == `ERET_WORD) begin
                        c.alu_op = decode_pkg::ALU_ERET;
                        wr       = 1'b0;
                end else if (w[25:21] == 5'd0) begin
                        c.alu_op = decode_pkg::ALU_MFC0;
                end else if (w[25:21] == 5'd4) begin
                        c.alu_op = decode_pkg::ALU_MTC0;
                        wr       = 1'b0;
                end else begin
                        hit = 1'b0;
                end
        end
        default: hit = 1'b0;
        endcase
        if (op inside {[6'h08:6'h0f]}) begin
                c.alu_src    = decode_pkg::SRC_IMM;
                c.imm_signed = (op < 6'h0c);            // Arithmetic and compare forms
        end
        if (c.mem_type != decode_pkg::MEM_NOOP) begin
                c.alu_src     = decode_pkg::SRC_IMM;
                c.imm_signed  = 1'b1;
                c.mem_size    = (op[1:0] == 2'b00) ? decode_pkg::SZ_BYTE :
                                (op[1:0] == 2'b01) ? decode_pkg::SZ_HALF : decode_pkg::SZ_FULL;
                c.load_signed = (c.mem_type == decode_pkg::MEM_LOAD) && !op[2] && !op[1];
                wr            = (c.mem_type == decode_pkg::MEM_LOAD);
        end
        if (!hit) begin
                link   = (op == 6'h03) || (op == 6'h00 && fn == 6'h09) ||
                         (op == 6'h01 && rt inside {5'd16, 5'd17});
                branch = link || op inside {[6'h02:6'h07]} || (op == 6'h00 && fn == 6'h08) ||
                         (op == 6'h01 && rt inside {5'd0, 5'd1});
                c                = base;
                c.undefined_inst = !branch;
                wr               = link;
                if (link) begin
                        c.alu_op      = decode_pkg::ALU_OUTA;
                        c.alu_src     = decode_pkg::SRC_PCA;
                        c.wb_reg_dest = `LINK_REG;
                end
        end
        c.wb_reg_en = wr;
        if (!wr)
                c.wb_reg_dest = '0;
        return c;
endfunction

function automatic logic [`INST_W-1:0] model_imm(input logic [`INST_W-1:0] w);
        decode_pkg::decode_ctrl_t c;
        c = model_ctrl(w);
        if (c.alu_src == decode_pkg::SRC_IMM)
                return c.imm_signed ? {{16{w[15]}}, w[15:0]} : {16'h0000, w[15:0]};
        if (c.alu_src == decode_pkg::SRC_SFT)
                return {27'd0, w[10:6]};
        return '0;
endfunction

`endif

// ==== verif/tb_decode_stage.sv ====
`timescale 1ns/1ns
`include "decode_config.svh"

module tb_decode_stage;

        localparam int CYCLE_LIMIT = 900;               // 804 test cycles plus margin
        localparam logic [26*6-1:0] R_FUNCTS = {6'h20, 6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b,
                6'h24, 6'h25, 6'h26, 6'h27, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h10,
                6'h12, 6'h11, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h0d, 6'h0c};
        localparam logic [16*6-1:0] I_OPS = {6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e,
                6'h0f, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};
        // SPECIAL2, MOVZ, MOVN, SYNC, PREF, WAIT as opcode and funct pairs
        localparam logic [6*12-1:0] DROPPED = {6'h1c, 6'h00, 6'h00, 6'h0a, 6'h00, 6'h0b,
                6'h00, 6'h0f, 6'h33, 6'h00, 6'h10, 6'h20};

        logic                           clk;
        logic                           rst_n;
        logic                           inst_valid;
        logic                           hold;
        logic [`INST_W-1:0]             instruction;
        logic                           out_valid;
        decode_pkg::decode_ctrl_t       ctrl;
        logic [`INST_W-1:0]             imm;
        logic                           exp_valid;
        decode_pkg::decode_ctrl_t       exp_ctrl;
        logic [`INST_W-1:0]             exp_imm;
        integer                         seed = 32'hd317;
        int                             cycles = 0;
        int                             errors = 0;
        int                             total_errors = 0;
        int                             tests_failed = 0;

        `include "decode_model.svh"

        decode_stage DUT (
                .clk            (clk),
                .rst_n          (rst_n),
                .inst_valid     (inst_valid),
                .hold           (hold),
                .instruction    (instruction),
                .out_valid      (out_valid),
                .ctrl           (ctrl),
                .imm            (imm)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // One-entry expected register with the same hold rule
        always @(posedge clk) begin
                if (!rst_n) begin
                        exp_valid <= 1'b0;
                        exp_ctrl  <= '0;
                end else if (!hold) begin
                        exp_valid <= inst_valid;
                        exp_ctrl  <= model_ctrl(instruction);
                end
                if (!hold)
                        exp_imm <= model_imm(instruction);
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= CYCLE_LIMIT) begin
                        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
                        $display("Simulation failed");
                        $finish;
                end
        end

        function automatic logic [`INST_W-1:0] gen_word(input int kind);
                logic [`INST_W-1:0]             w;
                decode_pkg::decode_ctrl_t       c;
                int                             pick;
                int                             idx;
                w    = $random(seed);
                pick = $unsigned($random(seed)) % 16;
                idx  = $unsigned($random(seed)) % 26;
                if (kind == 1) begin                    // Branches and jumps
                        if (pick < 6) begin
                                w[31:26] = 6'(pick + 2);
                        end else if (pick < 10) begin
                                w[31:26] = 6'h01;
                                w[20:16] = {w[20], 3'b000, w[16]};
                        end else begin
                                w[31:26] = 6'h00;
                                w[5:0]   = {5'b00100, w[0]};
                        end
                end else if (kind == 2) begin           // Outside the kept table
                        if (pick < 6) begin
                                w[31:26] = DROPPED[(pick*2+1)*6 +: 6];
                                if (w[31:26] == 6'h00 || w[31:26] == 6'h10)
                                        w[5:0] = DROPPED[pick*12 +: 6];
                                if (w[31:26] == 6'h10)
                                        w[25] = 1'b1;
                        end else begin
                                c = model_ctrl(w);
                                while (!c.undefined_inst) begin
                                        w = $random(seed);
                                        c = model_ctrl(w);
                                end
                        end
                end else if (pick < 8) begin
                        w[31:26] = 6'h00;
                        w[5:0]   = R_FUNCTS[idx*6 +: 6];
                end else if (pick < 14) begin
                        w[31:26] = I_OPS[(idx % 16)*6 +: 6];
                end else if (pick == 14) begin
                        w = `ERET_WORD;
                end else begin
                        w[31:26] = 6'h10;
                        w[25:21] = w[0] ? 5'd4 : 5'd0;  // MTC0 or MFC0
                end
                return w;
        endfunction

        task automatic check_outputs(input string name);
                assert (out_valid === exp_valid) else begin
                        $display("FAIL %s out_valid expected %b actual %b",
                                 name, exp_valid, out_valid);
                        errors++;
                end
                assert (ctrl === exp_ctrl) else begin
                        $display("FAIL %s ctrl expected %h actual %h", name, exp_ctrl, ctrl);
                        errors++;
                end
                assert (imm === exp_imm) else begin
                        $display("FAIL %s imm expected %h actual %h", name, exp_imm, imm);
                        errors++;
                end
        endtask

        task automatic end_test(input string name);
                if (errors == 0)
                        $display("PASS %s", name);
                else
                        $display("FAIL %s with %0d errors", name, errors);
                total_errors += errors;
                tests_failed += (errors != 0);
                errors = 0;
        endtask

        // kind 0 kept, 1 branch, 2 undefined, 3 hold, 4 valid
        task automatic run_test(input string name, input int n, input int kind);
                logic [`INST_W-1:0]     w;
                logic [31:0]            rnd;
                logic                   hold_n;
                int                     left;
                hold_n = 1'b0;
                left   = 0;
                for (int i = 0; i < n; i++) begin
                        w   = gen_word(kind);
                        rnd = $random(seed);
                        if (kind == 3) begin
                                if (left == 0) begin
                                        hold_n = ~hold_n;
                                        left   = 1 + rnd[2:0];
                                end
                                left = left - 1;
                        end
                        @(posedge clk);
                        instruction <= w;
                        hold        <= hold_n;
                        inst_valid  <= (kind == 3 || kind == 4) ? rnd[8] : 1'b1;
                        @(negedge clk);
                        check_outputs(name);
                        if (i > 0 && kind == 1)
                                assert (!ctrl.undefined_inst) else begin
                                        $display("FAIL %s undefined_inst expected 0 actual %b",
                                                 name, ctrl.undefined_inst);
                                        errors++;
                                end
                        if (i > 0 && kind == 2) begin
                                assert (ctrl.undefined_inst) else begin
                                        $display("FAIL %s undefined_inst expected 1 actual %b",
                                                 name, ctrl.undefined_inst);
                                        errors++;
                                end
                                assert (!ctrl.wb_reg_en) else begin
                                        $display("FAIL %s wb_reg_en expected 0 actual %b",
                                                 name, ctrl.wb_reg_en);
                                        errors++;
                                end
                        end
                end
                end_test(name);
        endtask

        initial begin
                rst_n       = 1'b0;
                inst_valid  = 1'b1;
                hold        = 1'b0;
                instruction = '0;
                repeat (3) @(posedge clk);
                rst_n <= 1'b1;
                @(negedge clk);
                assert (out_valid === 1'b0) else begin
                        $display("FAIL reset out_valid expected 0 actual %b", out_valid);
                        errors++;
                end
                assert (ctrl === '0) else begin
                        $display("FAIL reset ctrl expected 0 actual %h", ctrl);
                        errors++;
                end
                end_test("reset");
                run_test("random_kept", 300, 0);
                run_test("branches", 100, 1);
                run_test("undefined", 100, 2);
                run_test("hold", 200, 3);
                run_test("valid_tracking", 100, 4);
                $display("6 tests run, %0d failed, %0d errors", tests_failed, total_errors);
                if (total_errors == 0)
                        $display("Simulation passed");
                else
                        $display("Simulation failed");
                $finish;
        end

endmodule

// ==== decode_stage.f ====
+incdir+verilog
+incdir+verif
verilog/decode_pkg.sv
verilog/branch_detect.sv
verilog/ctrl_decode.sv
verilog/imm_extend.sv
verilog/decode_stage.sv
verif/tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f decode_stage.f --top-module tb_decode_stage \
        -Mdir obj_dir -o sim_decode_stage > build.log 2>&1 &&
./obj_dir/sim_decode_stage > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
